//--- logic/memPkg.sv
/* Memory-access shared types */
package memPkg;

    // *******************************************************************
    // widths that carry a meaning
    // *******************************************************************
    typedef logic [31:0] word_t;             // data word and byte address
    typedef logic [4:0]  regAddr_t;          // integer register number
    typedef logic [3:0]  excCode_t;          // trap cause
    typedef logic [1:0]  memSize_t;          // log2 of the access width in bytes

    localparam memSize_t sizeByte = 2'd0;
    localparam memSize_t sizeHalf = 2'd1;
    localparam memSize_t sizeWord = 2'd2;

    localparam excCode_t excLoadMisaligned   = 4'd4;
    localparam excCode_t excLoadAccessFault  = 4'd5;
    localparam excCode_t excStoreMisaligned  = 4'd6;
    localparam excCode_t excStoreAccessFault = 4'd7;

    localparam int    ramWords     = 256;
    localparam int    ramIndexBits = $clog2(ramWords);
    localparam word_t ramLimit     = ramWords * 4;  // first byte address past the RAM
    localparam word_t insnSize     = 32'd4;

    // *******************************************************************
    // enums
    // *******************************************************************
    typedef enum logic [1:0] {
        none,
        fenceI,
        fenceVma
    } fenceType_t;

    typedef enum logic [1:0] {
        idle,
        access,
        respond
    } lsuState_t;

    // *******************************************************************
    // bundles
    // *******************************************************************
    typedef struct packed {
        logic       isLoad;
        logic       isStore;
        logic       isBranch;
        fenceType_t fence;
        memSize_t   size;
        logic       isUnsigned;
        logic       regWriteEnable;
        logic       fromMemory;          // write-back takes the load result
        logic       csrWriteEnable;
    } memOp_t;

    typedef struct packed {
        logic     valid;
        excCode_t cause;
        word_t    value;
    } trapInfo_t;

    typedef struct packed {
        logic      valid;
        memOp_t    op;
        word_t     pc;
        word_t     memAddr;
        word_t     storeValue;
        regAddr_t  dstRegAddr;
        word_t     dstRegValue;
        logic      branchTaken;
        word_t     branchTarget;
        trapInfo_t trapInfo;
        logic      trapReturn;
    } exStage_t;

    typedef struct packed {
        logic      valid;
        memOp_t    op;
        word_t     pc;
        regAddr_t  dstRegAddr;
        word_t     dstRegValue;
        trapInfo_t trapInfo;
        logic      trapReturn;
    } maStage_t;

    typedef struct packed {
        logic     enable;
        logic     isStore;
        memSize_t size;
        logic     isUnsigned;
        word_t    addr;
        word_t    storeValue;
    } lsuReq_t;

    typedef struct packed {
        logic     done;
        logic     fault;
        excCode_t faultCause;
        word_t    loadValue;
    } lsuResp_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        word_t      paddr;
        word_t      pwdata;
        logic [3:0] pstrb;
    } apbReq_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apbResp_t;

endpackage

//--- logic/dataRam.sv
/* APB data RAM */
module dataRam
    import memPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apbReq_t  apbReq,
    output apbResp_t apbResp
);

    word_t                   mem [ramWords];
    word_t                   readData;
    logic [ramIndexBits-1:0] wordIndex;
    logic                    inRange;
    logic                    setupPhase;
    logic                    accessPhase;
    logic                    writeEnable;

    assign wordIndex   = apbReq.paddr[ramIndexBits+1:2];
    assign inRange     = apbReq.paddr < ramLimit;
    assign setupPhase  = apbReq.psel && !apbReq.penable;
    assign accessPhase = apbReq.psel && apbReq.penable;
    assign writeEnable = accessPhase && apbReq.pwrite && inRange;

    // read during setup so data is ready in the first access cycle
    always_ff @(posedge clk) begin
        if (setupPhase) begin
            readData <= mem[wordIndex];
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (apbReq.pstrb[lane]) begin
                    mem[wordIndex][lane*8 +: 8] <= apbReq.pwdata[lane*8 +: 8];
                end
            end
        end
    end

    // no wait states, out-of-range addresses get an error response
    always_comb begin
        apbResp.pready  = accessPhase;
        apbResp.pslverr = accessPhase && !inRange;
        apbResp.prdata  = readData;
    end

    // the master must keep address and direction from setup through access
    addrStableInAccess: assert property (
        @(posedge clk) disable iff (rst)
        accessPhase |-> $stable(apbReq.paddr) && $stable(apbReq.pwrite)
    );

endmodule

//--- logic/loadStoreUnit.sv
/* Load/store unit, APB master */
module loadStoreUnit
    import memPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  lsuReq_t  req,
    output lsuResp_t resp,
    output apbReq_t  apbReq,
    input  apbResp_t apbResp
);

    lsuState_t  state;
    lsuState_t  stateNext;
    logic       aligned;
    logic       misaligned;
    logic       start;                       // setup phase of a new transfer
    logic       busDone;
    logic [1:0] byteOffset;
    logic [3:0] laneMask;
    word_t      laneData;
    word_t      shiftedData;

    assign byteOffset = req.addr[1:0];

    // *******************************************************************
    // alignment check
    // *******************************************************************
    always_comb begin
        unique case (req.size)
            sizeByte: aligned = 1'b1;
            sizeHalf: aligned = !byteOffset[0];
            default:  aligned = byteOffset == 2'b00;
        endcase
    end

    assign misaligned = req.enable && !aligned;    // faults without touching the bus
    assign start      = req.enable && aligned && state != access;
    assign busDone    = state == access && apbResp.pready;

    // *******************************************************************
    // APB phase sequencing
    // *******************************************************************
    always_comb begin
        stateNext = state;
        unique case (state)
            idle, respond: begin
                // a new transfer may follow the last one with no gap
                if (start) begin
                    stateNext = access;
                end else begin
                    stateNext = idle;
                end
            end
            access: begin
                if (apbResp.pready) begin
                    stateNext = respond;
                end
            end
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= stateNext;
        end
    end

    // *******************************************************************
    // byte-lane placement toward the bus
    // *******************************************************************
    always_comb begin
        unique case (req.size)
            sizeByte: begin
                laneMask = 4'b0001 << byteOffset;
                laneData = {4{req.storeValue[7:0]}};
            end
            sizeHalf: begin
                laneMask = 4'b0011 << byteOffset;
                laneData = {2{req.storeValue[15:0]}};
            end
            default: begin
                laneMask = 4'b1111;
                laneData = req.storeValue;
            end
        endcase
    end

    always_comb begin
        apbReq.psel    = start || state == access;
        apbReq.penable = state == access;
        apbReq.pwrite  = req.isStore;
        apbReq.paddr   = {req.addr[31:2], 2'b00};  // lanes pick the bytes
        apbReq.pwdata  = laneData;
        apbReq.pstrb   = req.isStore ? laneMask : 4'b0000;
    end

    // *******************************************************************
    // response and load extension
    // *******************************************************************
    assign shiftedData = apbResp.prdata >> {byteOffset, 3'b000};

    always_comb begin
        unique case (req.size)
            sizeByte: resp.loadValue = req.isUnsigned ?
                {24'b0, shiftedData[7:0]} : {{24{shiftedData[7]}}, shiftedData[7:0]};
            sizeHalf: resp.loadValue = req.isUnsigned ?
                {16'b0, shiftedData[15:0]} : {{16{shiftedData[15]}}, shiftedData[15:0]};
            default:  resp.loadValue = shiftedData;
        endcase
    end

    always_comb begin
        resp.done  = misaligned || busDone;
        resp.fault = misaligned || (busDone && apbResp.pslverr);
        if (req.isStore) begin
            resp.faultCause = misaligned ? excStoreMisaligned : excStoreAccessFault;
        end else begin
            resp.faultCause = misaligned ? excLoadMisaligned : excLoadAccessFault;
        end
    end

    // every access phase follows a setup phase with the same write data and strobes
    penableAfterSetup: assert property (
        @(posedge clk) disable iff (rst)
        apbReq.penable |-> apbReq.psel && $past(apbReq.psel) &&
            $stable(apbReq.pwdata) && $stable(apbReq.pstrb)
    );

endmodule

//--- logic/memoryAccessStage.sv
/* Memory-access pipeline stage */
module memoryAccessStage
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  exStage_t    exIn,
    output lsuReq_t     lsuReq,
    input  lsuResp_t    lsuResp,
    output maStage_t    maOut,
    output logic        stall,
    output logic        flushReq,
    output word_t       nextPc,
    output logic        invalidateICache,
    output logic        invalidateTlb,
    output logic        loadWriteEnable,
    output regAddr_t    loadWriteAddr,
    output word_t       loadWriteValue,
    output logic [63:0] commitCount
);

    logic      valid;
    memOp_t    op;
    logic      isMemOp;
    logic      branchTaken;
    logic      accept;                       // operation leaves the stage this cycle
    word_t     dstRegValue;
    trapInfo_t trapInfo;

    assign valid       = exIn.valid;
    assign op          = exIn.op;
    assign isMemOp     = op.isLoad || op.isStore;
    assign branchTaken = op.isBranch && exIn.branchTaken;

    // *******************************************************************
    // load/store unit request
    // *******************************************************************
    always_comb begin
        lsuReq.enable     = valid && isMemOp && !exIn.trapInfo.valid;  // earlier trap wins
        lsuReq.isStore    = op.isStore;
        lsuReq.size       = op.size;
        lsuReq.isUnsigned = op.isUnsigned;
        lsuReq.addr       = exIn.memAddr;
        lsuReq.storeValue = exIn.storeValue;
    end

    // hold the execute stage until the unit reports completion
    assign stall  = lsuReq.enable && !lsuResp.done;
    assign accept = valid && !stall;

    always_comb begin
        dstRegValue = op.fromMemory ? lsuResp.loadValue : exIn.dstRegValue;
    end

    // a fault from the unit overwrites the trap info, the bad address goes in value
    always_comb begin
        if (lsuReq.enable && lsuResp.done && lsuResp.fault) begin
            trapInfo.valid = 1'b1;
            trapInfo.cause = lsuResp.faultCause;
            trapInfo.value = exIn.memAddr;
        end else begin
            trapInfo = exIn.trapInfo;
        end
    end

    // *******************************************************************
    // control flow toward fetch
    // *******************************************************************
    always_comb begin
        invalidateICache = accept && (op.fence == fenceI || op.fence == fenceVma);
        invalidateTlb    = accept && op.fence == fenceVma;

        flushReq = accept && (branchTaken ||
                              op.csrWriteEnable ||
                              op.fence != none ||
                              trapInfo.valid ||
                              exIn.trapReturn);

        if (branchTaken) begin
            nextPc = exIn.branchTarget;
        end else begin
            nextPc = exIn.pc + insnSize;
        end
    end

    // Load results are forwarded to the register file in the cycle they arrive.
    // A faulting load writes nothing.
    always_comb begin
        loadWriteEnable = accept && op.isLoad && op.regWriteEnable && !trapInfo.valid;
        loadWriteAddr   = exIn.dstRegAddr;
        loadWriteValue  = dstRegValue;
    end

    // *******************************************************************
    // stage register and commit counter
    // *******************************************************************
    always_ff @(posedge clk) begin
        maOut.op          <= op;
        maOut.pc          <= exIn.pc;
        maOut.dstRegAddr  <= exIn.dstRegAddr;
        maOut.dstRegValue <= dstRegValue;
        maOut.trapInfo    <= trapInfo;
        maOut.trapReturn  <= exIn.trapReturn;
        if (rst || stall) begin
            maOut.valid <= 1'b0;                 // bubble while the access is in flight
        end else begin
            maOut.valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitCount <= '0;
        end else if (accept) begin
            commitCount <= commitCount + 64'd1;
        end
    end

    // the execute stage must hold its operation for the whole access
    reqStableDuringStall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(lsuReq)
    );

endmodule

//--- logic/memStageTop.sv
/* Memory stage top level */
module memStageTop
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  exStage_t    exIn,
    output maStage_t    maOut,
    output logic        stall,
    output logic        flushReq,
    output word_t       nextPc,
    output logic        invalidateICache,
    output logic        invalidateTlb,
    output logic        loadWriteEnable,
    output regAddr_t    loadWriteAddr,
    output word_t       loadWriteValue,
    output logic [63:0] commitCount
);

    lsuReq_t  lsuReq;
    lsuResp_t lsuResp;
    apbReq_t  apbReq;
    apbResp_t apbResp;

    memoryAccessStage u_memoryAccessStage (
        .clk              (clk),
        .rst              (rst),
        .exIn             (exIn),
        .lsuReq           (lsuReq),
        .lsuResp          (lsuResp),
        .maOut            (maOut),
        .stall            (stall),
        .flushReq         (flushReq),
        .nextPc           (nextPc),
        .invalidateICache (invalidateICache),
        .invalidateTlb    (invalidateTlb),
        .loadWriteEnable  (loadWriteEnable),
        .loadWriteAddr    (loadWriteAddr),
        .loadWriteValue   (loadWriteValue),
        .commitCount      (commitCount)
    );

    loadStoreUnit u_loadStoreUnit (
        .clk     (clk),
        .rst     (rst),
        .req     (lsuReq),
        .resp    (lsuResp),
        .apbReq  (apbReq),
        .apbResp (apbResp)
    );

    dataRam u_dataRam (
        .clk     (clk),
        .rst     (rst),
        .apbReq  (apbReq),
        .apbResp (apbResp)
    );

endmodule

//--- testbench/memStageChecker.sv
/* Memory stage checker */
module memStageChecker
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  exStage_t    exIn,
    input  maStage_t    maOut,
    input  logic        stall,
    input  logic        flushReq,
    input  word_t       nextPc,
    input  logic        invalidateICache,
    input  logic        invalidateTlb,
    input  logic        loadWriteEnable,
    input  regAddr_t    loadWriteAddr,
    input  word_t       loadWriteValue,
    input  logic [63:0] commitCount
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        maStage_t ma;
        logic     busy;                    // the operation needs a bus transfer
        logic     flush;
        word_t    nextPc;
        logic     invI;
        logic     invT;
        logic     lwe;
        regAddr_t lwa;
        word_t    lwv;
    } expect_t;

    word_t    shadow [ramWords];           // mirror of the RAM, updated in order
    maStage_t expQ [$];                    // accepted operations waiting for maOut
    expect_t  predicted;
    maStage_t head;
    logic     stallExpected = 1'b0;
    longint   acceptCount = 0;
    int       errorCount  = 0;
    int       checkCount  = 0;
    int       testCount   = 0;
    int       errorsAtTestStart = 0;

    // *******************************************************************
    // reference model
    // *******************************************************************
    function automatic expect_t predict(exStage_t e, word_t memWord);
        expect_t x;
        logic    aligned;
        logic    access;
        int      lane;
        word_t   shifted;
        word_t   loadValue;
        x       = '0;
        lane    = int'(e.memAddr[1:0]);
        shifted = memWord >> (lane * 8);   // addressed byte moves to lane 0
        case (e.op.size)
            sizeByte: aligned = 1'b1;
            sizeHalf: aligned = e.memAddr[0] == 1'b0;
            default:  aligned = e.memAddr[1:0] == 2'b00;
        endcase
        case (e.op.size)
            sizeByte: loadValue = e.op.isUnsigned ? {24'h0, shifted[7:0]}
                                                  : {{24{shifted[7]}}, shifted[7:0]};
            sizeHalf: loadValue = e.op.isUnsigned ? {16'h0, shifted[15:0]}
                                                  : {{16{shifted[15]}}, shifted[15:0]};
            default:  loadValue = shifted;
        endcase
        access = (e.op.isLoad || e.op.isStore) && !e.trapInfo.valid;
        x.busy = access && aligned;       // out-of-range addresses still reach the bus
        x.ma.trapInfo = e.trapInfo;       // an incoming trap passes through
        if (access && !aligned) begin
            x.ma.trapInfo.valid = 1'b1;
            x.ma.trapInfo.cause = e.op.isStore ? excStoreMisaligned : excLoadMisaligned;
            x.ma.trapInfo.value = e.memAddr;
        end else if (access && e.memAddr >= ramLimit) begin
            x.ma.trapInfo.valid = 1'b1;
            x.ma.trapInfo.cause = e.op.isStore ? excStoreAccessFault : excLoadAccessFault;
            x.ma.trapInfo.value = e.memAddr;
        end
        x.ma.valid       = 1'b1;
        x.ma.op          = e.op;
        x.ma.pc          = e.pc;
        x.ma.dstRegAddr  = e.dstRegAddr;
        x.ma.dstRegValue = e.op.fromMemory ? loadValue : e.dstRegValue;
        x.ma.trapReturn  = e.trapReturn;
        x.flush  = (e.op.isBranch && e.branchTaken) || e.op.csrWriteEnable ||
                   e.op.fence != none || x.ma.trapInfo.valid || e.trapReturn;
        x.nextPc = (e.op.isBranch && e.branchTaken) ? e.branchTarget : e.pc + 32'd4;
        x.invI   = e.op.fence != none;
        x.invT   = e.op.fence == fenceVma;
        x.lwe    = e.op.isLoad && e.op.regWriteEnable && !x.ma.trapInfo.valid;
        x.lwa    = e.dstRegAddr;
        x.lwv    = x.ma.dstRegValue;
        return x;
    endfunction

    task automatic storeToShadow(exStage_t e, trapInfo_t t);
        int lane;
        int bytes;
        lane  = int'(e.memAddr[1:0]);
        bytes = 1 << e.op.size;
        if (e.op.isStore && !t.valid) begin  // a faulting store leaves memory alone
            for (int i = 0; i < bytes; i++) begin
                shadow[e.memAddr[ramIndexBits+1:2]][(lane + i) * 8 +: 8] =
                    e.storeValue[i * 8 +: 8];
            end
        end
    endtask

    // *******************************************************************
    // comparison
    // *******************************************************************
    task automatic compareValue(string name, logic [63:0] got, logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (maOut.valid) begin
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("maOut carried a valid operation that was never accepted");
                end else begin
                    head = expQ.pop_front();
                    compareValue("maOut.op", 64'(maOut.op), 64'(head.op));
                    compareValue("maOut.pc", 64'(maOut.pc), 64'(head.pc));
                    compareValue("maOut.dstRegAddr", 64'(maOut.dstRegAddr),
                                 64'(head.dstRegAddr));
                    compareValue("maOut.trapInfo", 64'(maOut.trapInfo), 64'(head.trapInfo));
                    compareValue("maOut.trapReturn", 64'(maOut.trapReturn),
                                 64'(head.trapReturn));
                    if (!head.trapInfo.valid) begin  // a faulted load has no result
                        compareValue("maOut.dstRegValue", 64'(maOut.dstRegValue),
                                     64'(head.dstRegValue));
                    end
                end
            end
            compareValue("commitCount", commitCount, 64'(acceptCount));
            if (exIn.valid) begin
                predicted = predict(exIn, exIn.memAddr < ramLimit ?
                                    shadow[exIn.memAddr[ramIndexBits+1:2]] : '0);
            end else begin
                predicted = '0;
            end
            // a bus transfer holds the execute stage for its setup cycle only
            stallExpected = predicted.busy && !stallExpected;
            compareValue("stall", 64'(stall), 64'(stallExpected));
            if (exIn.valid && !stall) begin
                compareValue("flushReq", 64'(flushReq), 64'(predicted.flush));
                compareValue("nextPc", 64'(nextPc), 64'(predicted.nextPc));
                compareValue("invalidateICache", 64'(invalidateICache), 64'(predicted.invI));
                compareValue("invalidateTlb", 64'(invalidateTlb), 64'(predicted.invT));
                compareValue("loadWriteEnable", 64'(loadWriteEnable), 64'(predicted.lwe));
                if (predicted.lwe) begin
                    compareValue("loadWriteAddr", 64'(loadWriteAddr), 64'(predicted.lwa));
                    compareValue("loadWriteValue", 64'(loadWriteValue), 64'(predicted.lwv));
                end
                expQ.push_back(predicted.ma);
                storeToShadow(exIn, predicted.ma.trapInfo);
                acceptCount++;
            end else begin
                // nothing leaves the stage, so nothing may reach fetch
                compareValue("flushReq", 64'(flushReq), 64'd0);
                compareValue("loadWriteEnable", 64'(loadWriteEnable), 64'd0);
            end
        end
    end

    // *******************************************************************
    // reporting
    // *******************************************************************
    function automatic int pending();
        return expQ.size();
    endfunction

    task automatic endTest(string name);
        testCount++;
        $display("test %0d %-10s %s, %0d errors", testCount, name,
                 errorCount == errorsAtTestStart ? "passed" : "failed",
                 errorCount - errorsAtTestStart);
        errorsAtTestStart = errorCount;
    endtask

    task automatic report();
        $display("%0d tests, %0d operations, %0d checks, %0d errors",
                 testCount, acceptCount, checkCount, errorCount);
    endtask

endmodule

//--- testbench/memStageTb.sv
/* Memory stage testbench */
module memStageTb
    import memPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int opBudget   = 800;                 // upper bound on operations issued
    localparam int watchdogNs = opBudget * 3 * 4 + 400;

    logic        clk;
    logic        rst;
    exStage_t    exIn;
    maStage_t    maOut;
    logic        stall;
    logic        flushReq;
    word_t       nextPc;
    logic        invalidateICache;
    logic        invalidateTlb;
    logic        loadWriteEnable;
    regAddr_t    loadWriteAddr;
    word_t       loadWriteValue;
    logic [63:0] commitCount;
    integer      seed = 95959;
    word_t       pc   = 32'h0000_1000;

    memStageTop u_memStageTop (.*);

    memStageChecker u_memStageChecker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: the DUT stopped accepting operations");
        $display("Test FAILED");
        $finish;
    end

    // *******************************************************************
    // operation builders and driver
    // *******************************************************************
    function automatic word_t fillPattern(word_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic exStage_t loadOp(memSize_t size, logic uns, word_t addr, regAddr_t rd);
        exStage_t e;
        e = '0;
        e.op.isLoad = 1'b1;
        e.op.size = size;
        e.op.isUnsigned = uns;
        e.op.regWriteEnable = 1'b1;
        e.op.fromMemory = 1'b1;
        e.memAddr = addr;
        e.dstRegAddr = rd;
        return e;
    endfunction

    function automatic exStage_t storeOp(memSize_t size, word_t addr, word_t data);
        exStage_t e;
        e = '0;
        e.op.isStore = 1'b1;
        e.op.size = size;
        e.memAddr = addr;
        e.storeValue = data;
        return e;
    endfunction

    function automatic exStage_t aluOp(regAddr_t rd, word_t value);
        exStage_t e;
        e = '0;
        e.op.regWriteEnable = 1'b1;
        e.dstRegAddr = rd;
        e.dstRegValue = value;
        return e;
    endfunction

    task automatic issue(exStage_t op);
        op.valid = 1'b1;
        op.pc = pc;
        pc = pc + 32'd4;
        exIn <= op;
        @(posedge clk);
        while (stall) @(posedge clk);        // execute stage holds its operation
    endtask

    // the test line is printed between edges, once every result has come out
    task automatic finishTest(string name);
        exIn.valid <= 1'b0;
        @(negedge clk);
        while (u_memStageChecker.pending() != 0) @(negedge clk);
        u_memStageChecker.endTest(name);
        @(posedge clk);
    endtask

    task automatic issueRandom();
        exStage_t e;
        int       kind;
        memSize_t size;
        word_t    addr;
        regAddr_t rd;
        kind = {$random(seed)} % 8;
        size = memSize_t'({$random(seed)} % 3);
        rd   = regAddr_t'({$random(seed)} % 32);
        addr = ({$random(seed)} % 8 == 0) ? 32'h400 + {$random(seed)} % 64
                                            : {$random(seed)} % 256;
        e = aluOp(rd, $random(seed));
        case (kind)
            0, 1: e = loadOp(size, 1'($random(seed)), addr, rd);
            2:    e = storeOp(size, addr, $random(seed));
            4: begin
                e.op.isBranch = 1'b1;
                e.branchTaken = 1'($random(seed));
                e.branchTarget = {$random(seed)} & 32'hFFFF_FFFC;
            end
            5:    e.op.csrWriteEnable = 1'b1;
            6:    e.op.fence = ($random(seed) & 1) ? fenceI : fenceVma;
            7: begin
                e = loadOp(size, 1'b0, addr, rd);
                e.trapInfo = '{valid: 1'b1, cause: 4'd2, value: $random(seed)};
                e.trapReturn = 1'($random(seed));
            end
            default: ;
        endcase
        issue(e);
    endtask

    // *******************************************************************
    // test sequence
    // *******************************************************************
    initial begin
        exStage_t e;
        rst  = 1'b1;
        exIn = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // word fill of the region that loads read from
        for (int w = 0; w < 64; w++) issue(storeOp(sizeWord, w * 4, fillPattern(w * 4)));
        issue(storeOp(sizeByte, 32'h21, 32'h0000_0081));
        issue(storeOp(sizeByte, 32'h23, 32'h0000_007F));
        issue(storeOp(sizeHalf, 32'h26, 32'h0000_8A5C));
        issue(storeOp(sizeWord, 32'h28, 32'hF00D_CAFE));
        for (int a = 32'h20; a < 32'h2C; a++) begin
            issue(loadOp(sizeByte, 1'b0, a, 5'd1));
            issue(loadOp(sizeByte, 1'b1, a, 5'd2));
            if (a % 2 == 0) issue(loadOp(sizeHalf, 1'b0, a, 5'd3));
            if (a % 2 == 0) issue(loadOp(sizeHalf, 1'b1, a, 5'd4));
            if (a % 4 == 0) issue(loadOp(sizeWord, 1'b0, a, 5'd5));
        end
        finishTest("loadstore");

        issue(loadOp(sizeHalf, 1'b0, 32'h31, 5'd6));
        issue(loadOp(sizeWord, 1'b1, 32'h32, 5'd7));
        issue(storeOp(sizeWord, 32'h33, 32'h1111_2222));
        issue(storeOp(sizeHalf, 32'h35, 32'h3333_4444));
        issue(loadOp(sizeWord, 1'b0, 32'h30, 5'd8));
        issue(loadOp(sizeWord, 1'b0, 32'h34, 5'd9));
        finishTest("misalign");

        issue(loadOp(sizeWord, 1'b0, 32'h400, 5'd10));
        issue(storeOp(sizeByte, 32'h803, 32'h55));
        issue(loadOp(sizeWord, 1'b0, 32'h0, 5'd10));    // the RAM word that 0x800 aliases
        e = storeOp(sizeWord, 32'h40, 32'hDEAD_BEEF);
        e.trapInfo = '{valid: 1'b1, cause: 4'd2, value: 32'h0000_0013};
        issue(e);
        issue(loadOp(sizeWord, 1'b0, 32'h40, 5'd11));   // still the fill value
        finishTest("range");

        for (int k = 0; k < 6; k++) begin
            e = aluOp(5'd12, 32'h600D_0000 + k);
            e.op.isBranch = k < 2;
            e.branchTaken = k == 0;
            e.branchTarget = 32'h0000_4000;
            e.op.csrWriteEnable = k == 2;
            e.op.fence = k == 3 ? fenceI : (k == 4 ? fenceVma : none);
            e.trapReturn = k == 5;
            issue(e);
        end
        finishTest("flush");

        issue(aluOp(5'd13, 32'h1234_5678));
        issue(loadOp(sizeWord, 1'b0, 32'h44, 5'd14));
        e = loadOp(sizeWord, 1'b0, 32'h48, 5'd15);
        e.op.regWriteEnable = 1'b0;
        issue(e);
        finishTest("bypass");

        for (int n = 0; n < 300; n++) issueRandom();
        finishTest("random");

        @(negedge clk);
        u_memStageChecker.report();
        if (u_memStageChecker.errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
logic/memPkg.sv
logic/dataRam.sv
logic/loadStoreUnit.sv
logic/memoryAccessStage.sv
logic/memStageTop.sv
testbench/memStageChecker.sv
testbench/memStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory stage simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module memStageTb -Mdir obj_dir -f all.f

out=$(./obj_dir/VmemStageTb)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx "Test OK"
